/* rtl/mips_pkg.sv */
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_en_t;

    // primary opcodes, inst[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // SPECIAL function field, inst[5:0]
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef struct packed {
        word_t     pc;
        alu_op_e   alu_op;
        word_t     src1;     // shift amount for sll/srl/sra
        word_t     src2;
        word_t     sdata;    // store data
        reg_addr_t waddr;
        logic      wreg;
        logic      load;
        logic      store;
    } id_ex_t;

    typedef struct packed {
        word_t     pc;
        word_t     result;   // data address for lw/sw
        word_t     sdata;
        reg_addr_t waddr;
        logic      wreg;
        logic      load;
        logic      store;
    } ex_mem_t;

    typedef struct packed {
        word_t     pc;
        word_t     result;
        reg_addr_t waddr;
        logic      wreg;
        logic      load;
    } mem_wb_t;

endpackage

/* rtl/pipe_reg.sv */
module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     hold_i,
    input  logic     bubble_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // an all-zero payload carries no write, load or store
    always_ff @(posedge clk) begin
        if (reset_i || bubble_i) begin
            q_o <= '0;
        end else if (!hold_i) begin
            q_o <= d_i;
        end
    end

endmodule

/* rtl/fetch_stage.sv */
module fetch_stage import mips_pkg::*; #(
    parameter word_t RESET_PC = 32'h0
) (
    input  logic  clk,
    input  logic  reset_i,
    input  logic  stall_i,
    output word_t iaddr_o,
    output logic  ice_o,
    output word_t pc_o
);

    word_t fetch_pc_q;  // next sequential fetch
    word_t dec_pc_q;    // address of the word now on inst_i

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_pc_q <= RESET_PC;
            dec_pc_q   <= RESET_PC;
        end else begin
            if (!stall_i) begin
                fetch_pc_q <= fetch_pc_q + 32'd4;
                dec_pc_q   <= fetch_pc_q;
            end
        end
    end

    // refetch the stalled word so it shows up again next cycle
    assign iaddr_o = stall_i ? dec_pc_q : fetch_pc_q;
    assign ice_o   = !reset_i;  // RESET_PC goes out in the first cycle out of reset
    assign pc_o    = dec_pc_q;

endmodule

/* rtl/reg_file.sv */
module reg_file import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            regs <= '{default: '0};
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // writeback result bypasses into decode in the same cycle
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (we_i && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (we_i && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

/* rtl/decode_stage.sv */
module decode_stage import mips_pkg::*; (
    input  word_t     inst_i,
    input  word_t     pc_i,
    input  word_t     rdata1_i,
    input  word_t     rdata2_i,
    output reg_addr_t raddr1_o,
    output reg_addr_t raddr2_o,
    input  id_ex_t    ex_fwd_i,
    input  word_t     ex_result_i,
    input  ex_mem_t   mem_fwd_i,
    output logic      stall_o,
    output id_ex_t    id_ex_o
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [4:0]  sa;
    logic [15:0] imm;

    alu_op_e     alu_op;
    reg_addr_t   waddr;
    word_t       imm_ext;
    word_t       rs_val;
    word_t       rt_val;
    logic        wreg;
    logic        load;
    logic        store;
    logic        use_rs;
    logic        use_rt;
    logic        use_imm;
    logic        is_shift;

    // newest non-load producer wins, r0 never forwards
    function automatic word_t fwd_sel(input reg_addr_t ra, input word_t rf,
                                      input id_ex_t ex, input word_t ex_res,
                                      input ex_mem_t mem);
        if (ra != '0 && ex.wreg && !ex.load && ex.waddr == ra) return ex_res;
        if (ra != '0 && mem.wreg && !mem.load && mem.waddr == ra) return mem.result;
        return rf;
    endfunction

    // load result not yet on the writeback bypass
    function automatic logic load_hit(input reg_addr_t ra, input id_ex_t ex,
                                      input ex_mem_t mem);
        return (ra != '0) && ((ex.load && ex.waddr == ra) || (mem.load && mem.waddr == ra));
    endfunction

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign sa     = inst_i[10:6];
    assign funct  = inst_i[5:0];
    assign imm    = inst_i[15:0];

    always_comb begin
        alu_op  = ALU_ADD;
        waddr   = rt;
        imm_ext = {{16{imm[15]}}, imm};
        wreg    = 1'b0;
        load    = 1'b0;
        store   = 1'b0;
        use_rs  = 1'b1;
        use_rt  = 1'b0;
        use_imm = 1'b1;
        case (opcode)
            OP_SPECIAL: begin
                waddr   = rd;
                wreg    = 1'b1;
                use_rt  = 1'b1;
                use_imm = 1'b0;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_SRA:  alu_op = ALU_SRA;
                    default: wreg = 1'b0;  // retires as a no-op
                endcase
            end
            OP_ADDIU: wreg = 1'b1;
            OP_SLTI: begin
                alu_op = ALU_SLT;
                wreg   = 1'b1;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                alu_op  = (opcode == OP_ANDI) ? ALU_AND :
                          (opcode == OP_ORI)  ? ALU_OR : ALU_XOR;
                imm_ext = {16'h0, imm};
                wreg    = 1'b1;
            end
            OP_LUI: begin
                alu_op  = ALU_LUI;
                imm_ext = {imm, 16'h0};
                use_rs  = 1'b0;
                wreg    = 1'b1;
            end
            OP_LW: begin
                wreg = 1'b1;
                load = 1'b1;
            end
            OP_SW: begin
                use_rt = 1'b1;
                store  = 1'b1;
            end
            default: use_rs = 1'b0;
        endcase
    end

    assign is_shift = (alu_op == ALU_SLL) || (alu_op == ALU_SRL) || (alu_op == ALU_SRA);

    assign raddr1_o = rs;
    assign raddr2_o = rt;
    assign rs_val   = fwd_sel(rs, rdata1_i, ex_fwd_i, ex_result_i, mem_fwd_i);
    assign rt_val   = fwd_sel(rt, rdata2_i, ex_fwd_i, ex_result_i, mem_fwd_i);

    assign stall_o = (use_rs && !is_shift && load_hit(rs, ex_fwd_i, mem_fwd_i)) ||
                     (use_rt && load_hit(rt, ex_fwd_i, mem_fwd_i));

    always_comb begin
        id_ex_o.pc     = pc_i;
        id_ex_o.alu_op = alu_op;
        id_ex_o.src1   = is_shift ? {27'h0, sa} : rs_val;
        id_ex_o.src2   = use_imm ? imm_ext : rt_val;
        id_ex_o.sdata  = rt_val;
        id_ex_o.waddr  = waddr;
        id_ex_o.wreg   = wreg;
        id_ex_o.load   = load;
        id_ex_o.store  = store;
    end

endmodule

/* rtl/execute_stage.sv */
module execute_stage import mips_pkg::*; (
    input  id_ex_t  id_ex_i,
    output word_t   result_o,
    output ex_mem_t ex_mem_o
);

    word_t      a;
    word_t      b;
    logic [4:0] shamt;

    assign a     = id_ex_i.src1;
    assign b     = id_ex_i.src2;
    assign shamt = a[4:0];  // sa field for shifts

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:  result_o = a + b;
            ALU_SUB:  result_o = a - b;
            ALU_AND:  result_o = a & b;
            ALU_OR:   result_o = a | b;
            ALU_XOR:  result_o = a ^ b;
            ALU_NOR:  result_o = ~(a | b);
            ALU_SLT:  result_o = {31'h0, $signed(a) < $signed(b)};
            ALU_SLTU: result_o = {31'h0, a < b};
            ALU_SLL:  result_o = b << shamt;
            ALU_SRL:  result_o = b >> shamt;
            ALU_SRA:  result_o = word_t'($signed(b) >>> shamt);
            ALU_LUI:  result_o = b;  // already shifted up in decode
            default:  result_o = a + b;
        endcase
    end

    // lw/sw address comes straight out of the adder
    always_comb begin
        ex_mem_o.pc     = id_ex_i.pc;
        ex_mem_o.result = result_o;
        ex_mem_o.sdata  = id_ex_i.sdata;
        ex_mem_o.waddr  = id_ex_i.waddr;
        ex_mem_o.wreg   = id_ex_i.wreg;
        ex_mem_o.load   = id_ex_i.load;
        ex_mem_o.store  = id_ex_i.store;
    end

endmodule

/* rtl/writeback_stage.sv */
module writeback_stage import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  ex_mem_t   ex_mem_i,
    input  word_t     dout_i,
    output logic      we_o,
    output reg_addr_t waddr_o,
    output word_t     wdata_o,
    output word_t     debug_wb_pc_o,
    output byte_en_t  debug_wb_rf_wen_o
);

    mem_wb_t mem_wb_d;
    mem_wb_t mem_wb_q;

    always_comb begin
        mem_wb_d.pc     = ex_mem_i.pc;
        mem_wb_d.result = ex_mem_i.result;
        mem_wb_d.waddr  = ex_mem_i.waddr;
        mem_wb_d.wreg   = ex_mem_i.wreg;
        mem_wb_d.load   = ex_mem_i.load;
    end

    pipe_reg #(.payload_t(mem_wb_t)) memwb_reg0 (
        .clk      (clk      ),
        .reset_i  (reset_i  ),
        .hold_i   (1'b0     ),
        .bubble_i (1'b0     ),
        .d_i      (mem_wb_d ),
        .q_o      (mem_wb_q )
    );

    // load data arrives from memory while the load sits here
    assign wdata_o = mem_wb_q.load ? dout_i : mem_wb_q.result;
    assign waddr_o = mem_wb_q.waddr;
    assign we_o    = mem_wb_q.wreg && (mem_wb_q.waddr != '0);

    assign debug_wb_pc_o     = mem_wb_q.pc;
    assign debug_wb_rf_wen_o = {4{we_o}};

endmodule

/* rtl/mini_mips_core.sv */
module mini_mips_core import mips_pkg::*; #(
    parameter word_t RESET_PC = 32'h0
) (
    input  logic      clk,
    input  logic      reset_i,

    output word_t     iaddr_o,
    output logic      ice_o,
    input  word_t     inst_i,

    input  word_t     dout_i,
    output logic      dce_o,
    output word_t     daddr_o,
    output byte_en_t  we_o,
    output word_t     din_o,

    output word_t     debug_wb_pc_o,
    output byte_en_t  debug_wb_rf_wen_o,
    output reg_addr_t debug_wb_rf_wnum_o,
    output word_t     debug_wb_rf_wdata_o
);

    logic      stall;
    word_t     dec_pc;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    word_t     rdata1;
    word_t     rdata2;
    id_ex_t    id_ex_d;
    id_ex_t    id_ex_q;
    word_t     ex_result;
    ex_mem_t   ex_mem_d;
    ex_mem_t   ex_mem_q;
    logic      wb_we;
    reg_addr_t wb_waddr;
    word_t     wb_wdata;

    fetch_stage #(.RESET_PC(RESET_PC)) fetch_stage0 (
        .clk      (clk     ),
        .reset_i  (reset_i ),
        .stall_i  (stall   ),
        .iaddr_o  (iaddr_o ),
        .ice_o    (ice_o   ),
        .pc_o     (dec_pc  )
    );

    reg_file reg_file0 (
        .clk      (clk      ),
        .reset_i  (reset_i  ),
        .raddr1_i (raddr1   ),
        .raddr2_i (raddr2   ),
        .rdata1_o (rdata1   ),
        .rdata2_o (rdata2   ),
        .we_i     (wb_we    ),
        .waddr_i  (wb_waddr ),
        .wdata_i  (wb_wdata )
    );

    decode_stage decode_stage0 (
        .inst_i      (inst_i    ),
        .pc_i        (dec_pc    ),
        .rdata1_i    (rdata1    ),
        .rdata2_i    (rdata2    ),
        .raddr1_o    (raddr1    ),
        .raddr2_o    (raddr2    ),
        .ex_fwd_i    (id_ex_q   ),
        .ex_result_i (ex_result ),
        .mem_fwd_i   (ex_mem_q  ),
        .stall_o     (stall     ),
        .id_ex_o     (id_ex_d   )
    );

    // a stalled decode leaves a bubble in execute
    pipe_reg #(.payload_t(id_ex_t)) idex_reg0 (
        .clk      (clk     ),
        .reset_i  (reset_i ),
        .hold_i   (1'b0    ),
        .bubble_i (stall   ),
        .d_i      (id_ex_d ),
        .q_o      (id_ex_q )
    );

    execute_stage execute_stage0 (
        .id_ex_i  (id_ex_q   ),
        .result_o (ex_result ),
        .ex_mem_o (ex_mem_d  )
    );

    pipe_reg #(.payload_t(ex_mem_t)) exmem_reg0 (
        .clk      (clk      ),
        .reset_i  (reset_i  ),
        .hold_i   (1'b0     ),
        .bubble_i (1'b0     ),
        .d_i      (ex_mem_d ),
        .q_o      (ex_mem_q )
    );

    // memory stage is just the data port
    assign daddr_o = ex_mem_q.result;
    assign din_o   = ex_mem_q.sdata;
    assign dce_o   = ex_mem_q.load || ex_mem_q.store;
    assign we_o    = {4{ex_mem_q.store}};  // word stores only

    writeback_stage writeback_stage0 (
        .clk               (clk               ),
        .reset_i           (reset_i           ),
        .ex_mem_i          (ex_mem_q          ),
        .dout_i            (dout_i            ),
        .we_o              (wb_we             ),
        .waddr_o           (wb_waddr          ),
        .wdata_o           (wb_wdata          ),
        .debug_wb_pc_o     (debug_wb_pc_o     ),
        .debug_wb_rf_wen_o (debug_wb_rf_wen_o )
    );

    assign debug_wb_rf_wnum_o  = wb_waddr;
    assign debug_wb_rf_wdata_o = wb_wdata;

endmodule

/* test/mini_mips_properties.sv */
module mini_mips_properties import mips_pkg::*; (
    input logic     clk,
    input logic     reset_i,
    input word_t    iaddr_o,
    input logic     ice_o,
    input logic     dce_o,
    input byte_en_t we_o,
    input byte_en_t debug_wb_rf_wen_o
);

    // first fetch goes out at the address held through reset
    assert property (@(posedge clk) $fell(reset_i) |-> ice_o && (iaddr_o == $past(iaddr_o)))
        else $error("first fetch after reset missing or not at the reset address");

    assert property (@(posedge clk) disable iff (reset_i) (we_o != '0) |-> dce_o)
        else $error("store strobe without dce_o");

    assert property (@(posedge clk)
        (debug_wb_rf_wen_o == 4'h0) || (debug_wb_rf_wen_o == 4'hf))
        else $error("partial debug write enable");

    // a stall repeats the address, otherwise it steps one word
    assert property (@(posedge clk) disable iff (reset_i)
        !$past(reset_i) |->
            (iaddr_o == $past(iaddr_o)) || (iaddr_o == $past(iaddr_o) + 32'd4))
        else $error("iaddr_o neither held nor advanced by four");

endmodule

bind mini_mips_core mini_mips_properties props0 (
    .clk               (clk               ),
    .reset_i           (reset_i           ),
    .iaddr_o           (iaddr_o           ),
    .ice_o             (ice_o             ),
    .dce_o             (dce_o             ),
    .we_o              (we_o              ),
    .debug_wb_rf_wen_o (debug_wb_rf_wen_o )
);

/* test/tb_mini_mips.sv */
module tb_mini_mips import mips_pkg::*; ;

    localparam word_t RESET_PC = 32'h0;
    localparam word_t DBASE    = 32'h100;  // data window, 16 words
    localparam int    NPROG    = 200;

    logic      clk;
    logic      reset_i;
    word_t     iaddr_o;
    logic      ice_o;
    word_t     inst_i;
    word_t     dout_i;
    logic      dce_o;
    word_t     daddr_o;
    byte_en_t  we_o;
    word_t     din_o;
    word_t     debug_wb_pc_o;
    byte_en_t  debug_wb_rf_wen_o;
    reg_addr_t debug_wb_rf_wnum_o;
    word_t     debug_wb_rf_wdata_o;

    word_t imem [256];
    word_t dmem [16];
    word_t mregs [32];
    word_t mdmem [16];

    word_t     exp_pc_q [$];
    reg_addr_t exp_num_q [$];
    word_t     exp_data_q [$];
    word_t     st_addr_q [$];
    word_t     st_data_q [$];

    int retire_err = 0;
    int store_err  = 0;
    int fetch_err  = 0;
    int n_writes   = 0;
    int n_stores   = 0;
    int exp_writes = 0;
    int exp_stores = 0;

    mini_mips_core #(.RESET_PC(RESET_PC)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9e3779b1) ^ {addr[15:0], ~addr[15:0]} ^ 32'h5a5a0000;
    endfunction

    function automatic word_t enc_r(input logic [5:0] fn, input int rs, input int rt,
                                    input int rd, input logic [4:0] sa);
        return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], sa, fn};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input int rs, input int rt,
                                    input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    // in-order ISA reference for one instruction
    task automatic model_step(input word_t pc, input word_t inst);
        logic [5:0] op;
        logic [5:0] fn;
        word_t      a;
        word_t      b;
        word_t      sx;
        word_t      res;
        int         dst;
        logic       wr;
        op  = inst[31:26];
        fn  = inst[5:0];
        a   = mregs[inst[25:21]];
        b   = mregs[inst[20:16]];
        sx  = {{16{inst[15]}}, inst[15:0]};
        dst = inst[20:16];
        wr  = 1'b1;
        res = '0;
        case (op)
            OP_SPECIAL: begin
                dst = inst[15:11];
                case (fn)
                    FN_ADDU: res = a + b;
                    FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_NOR:  res = ~(a | b);
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                    FN_SLL:  res = b << inst[10:6];
                    FN_SRL:  res = b >> inst[10:6];
                    FN_SRA:  res = word_t'($signed(b) >>> inst[10:6]);
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDIU: res = a + sx;
            OP_SLTI:  res = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
            OP_ANDI:  res = a & {16'h0, inst[15:0]};
            OP_ORI:   res = a | {16'h0, inst[15:0]};
            OP_XORI:  res = a ^ {16'h0, inst[15:0]};
            OP_LUI:   res = {inst[15:0], 16'h0};
            OP_LW:    res = mdmem[((a + sx) - DBASE) >> 2];
            OP_SW: begin
                wr = 1'b0;
                mdmem[((a + sx) - DBASE) >> 2] = b;
                st_addr_q.push_back(a + sx);
                st_data_q.push_back(b);
                exp_stores++;
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != 0) begin
            mregs[dst] = res;
            exp_pc_q.push_back(pc);
            exp_num_q.push_back(reg_addr_t'(dst));
            exp_data_q.push_back(res);
            exp_writes++;
        end
    endtask

    task automatic build_program();
        int    kind;
        word_t inst;
        logic [5:0] fns [11] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                                 FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA};
        logic [5:0] ops [5] = '{OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI};
        foreach (imem[i]) imem[i] = '0;  // sll r0 acts as nop
        foreach (mregs[i]) mregs[i] = '0;
        for (int i = 0; i < 16; i++) begin
            dmem[i]  = fill_word(DBASE + 4 * i);
            mdmem[i] = dmem[i];
        end
        imem[0] = enc_i(OP_ORI, 0, 5, DBASE[15:0]);  // r5 is the load/store base
        for (int i = 1; i <= NPROG; i++) begin
            kind = $urandom % 20;
            if (kind < 9) begin
                inst = enc_r(fns[$urandom % 11], $urandom % 5, $urandom % 5,
                             $urandom % 5, 5'($urandom));
            end else if (kind < 14) begin
                inst = enc_i(ops[$urandom % 5], $urandom % 5, $urandom % 5, 16'($urandom));
            end else if (kind < 16) begin
                inst = enc_i(OP_LW, 5, $urandom % 5, 16'(4 * ($urandom % 16)));
            end else if (kind < 18) begin
                inst = enc_i(OP_SW, 5, $urandom % 5, 16'(4 * ($urandom % 16)));
            end else if (kind < 19) begin
                inst = ($urandom % 2) ? enc_r(6'h3f, 1, 2, 3, 5'h0) : 32'hfc21_0000;
            end else begin
                inst = enc_i(OP_LUI, 0, $urandom % 5, 16'($urandom));
            end
            imem[i] = inst;
        end
        for (int i = 0; i <= NPROG; i++) model_step(RESET_PC + 4 * i, imem[i]);
    endtask

    // synchronous instruction ROM and data RAM
    always @(posedge clk) begin
        if (ice_o) inst_i <= imem[8'((iaddr_o - RESET_PC) >> 2)];
        if (dce_o) begin
            if (we_o == 4'hf) dmem[4'((daddr_o - DBASE) >> 2)] <= din_o;
            else dout_i <= dmem[4'((daddr_o - DBASE) >> 2)];
        end
    end

    task automatic check_retire(input word_t pc, input reg_addr_t num, input word_t data,
                                input byte_en_t wen);
        n_writes++;
        if (exp_pc_q.size() == 0) begin
            $display("register write to r%0d at pc %h with nothing expected", num, pc);
            retire_err++;
            return;
        end
        if (wen != 4'hf) begin
            $display("ERROR debug_wb_rf_wen_o: got %h expected %h", wen, 4'hf);
            retire_err++;
        end
        if (pc != exp_pc_q[0]) begin
            $display("ERROR debug_wb_pc_o: got %h expected %h", pc, exp_pc_q[0]);
            retire_err++;
        end
        if (num != exp_num_q[0]) begin
            $display("ERROR debug_wb_rf_wnum_o: got %h expected %h", num, exp_num_q[0]);
            retire_err++;
        end
        if (data != exp_data_q[0]) begin
            $display("ERROR debug_wb_rf_wdata_o: got %h expected %h", data, exp_data_q[0]);
            retire_err++;
        end
        void'(exp_pc_q.pop_front());
        void'(exp_num_q.pop_front());
        void'(exp_data_q.pop_front());
    endtask

    task automatic check_store(input word_t addr, input word_t data, input byte_en_t we);
        n_stores++;
        if (st_addr_q.size() == 0) begin
            $display("store to %h with nothing expected", addr);
            store_err++;
            return;
        end
        if (we != 4'hf) begin
            $display("ERROR we_o: got %h expected %h", we, 4'hf);
            store_err++;
        end
        if (addr != st_addr_q[0]) begin
            $display("ERROR daddr_o: got %h expected %h", addr, st_addr_q[0]);
            store_err++;
        end
        if (data != st_data_q[0]) begin
            $display("ERROR din_o: got %h expected %h", data, st_data_q[0]);
            store_err++;
        end
        void'(st_addr_q.pop_front());
        void'(st_data_q.pop_front());
    endtask

    // outputs settle after the rising edge, sample mid-cycle
    always @(negedge clk) begin
        if (!reset_i) begin
            if (debug_wb_rf_wen_o != '0) begin
                check_retire(debug_wb_pc_o, debug_wb_rf_wnum_o, debug_wb_rf_wdata_o,
                             debug_wb_rf_wen_o);
            end
            if (dce_o && we_o != '0) check_store(daddr_o, din_o, we_o);
        end
    end

    initial begin
        int cycles;
        int errors;
        reset_i = 1'b1;
        inst_i  = '0;
        dout_i  = '0;
        void'($urandom(32'hc113fb0e));
        build_program();

        repeat (4) @(posedge clk);
        reset_i <= 1'b0;

        // first cycle out of reset fetches RESET_PC
        @(negedge clk);
        if (iaddr_o != RESET_PC) begin
            $display("ERROR iaddr_o: got %h expected %h", iaddr_o, RESET_PC);
            fetch_err++;
        end
        if (!ice_o) begin
            $display("ice_o low in the first cycle after reset");
            fetch_err++;
        end
        // pipeline is still empty, nothing can stall here
        @(negedge clk);
        if (iaddr_o != RESET_PC + 32'd4) begin
            $display("ERROR iaddr_o: got %h expected %h", iaddr_o, RESET_PC + 32'd4);
            fetch_err++;
        end
        $display("test first fetch: %s", (fetch_err == 0) ? "ok" : "failed");

        cycles = 0;
        while ((exp_pc_q.size() != 0 || st_addr_q.size() != 0) && cycles < 3000) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_pc_q.size() != 0 || st_addr_q.size() != 0) begin
            $display("timeout with %0d writes and %0d stores outstanding",
                     exp_pc_q.size(), st_addr_q.size());
            $display("RESULT: FAIL");
            $finish;
        end else begin
            // let the padding drain to catch stray writes
            cycles = 0;
            while (cycles < 20) begin
                @(negedge clk);
                cycles++;
            end
            $display("test retire order and values: %s", (retire_err == 0) ? "ok" : "failed");
            $display("test stores: %s", (store_err == 0) ? "ok" : "failed");
            $display("test counts: %s",
                     (n_writes == exp_writes && n_stores == exp_stores) ? "ok" : "failed");
            errors = fetch_err + retire_err + store_err;
            if (n_writes != exp_writes || n_stores != exp_stores) errors++;
            $display("writes %0d/%0d, stores %0d/%0d, errors %0d",
                     n_writes, exp_writes, n_stores, exp_stores, errors);
            if (errors == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

/* mini_mips_core.f */
rtl/mips_pkg.sv
rtl/pipe_reg.sv
rtl/fetch_stage.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/mini_mips_core.sv
test/mini_mips_properties.sv
test/tb_mini_mips.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
    -f mini_mips_core.f --top-module tb_mini_mips -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

echo "$out" | grep -q "RESULT: PASS"
